/* source/mpc_types.sv */
package mpc_types;

    // ------------------------------------------------------------
    // Read path configuration
    // ------------------------------------------------------------

    // Reorder slots, also the number of request credits
    localparam int ROB_SIZE = 8;

    // Payload of one read completion
    localparam int DATA_W   = 128;

    // Upstream and downstream request address
    localparam int ADDR_W   = 32;

    // Slot index width, at least one bit
    localparam int ROB_ID_W = (ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1;

    // ------------------------------------------------------------
    // Shared types
    // ------------------------------------------------------------

    // Slot ID carried on the downstream issue and completion
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // One read payload
    typedef logic [DATA_W-1:0]   data_t;

endpackage

/* source/rob_entry.sv */
module rob_entry #(
    parameter int DataWidth = mpc_types::DATA_W
)
(
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    enq_valid,
    output logic                    enq_ready,
    input  logic [DataWidth-1:0]    enq_data,

    output logic                    deq_valid,
    input  logic                    deq_ready,
    output logic [DataWidth-1:0]    deq_data
);

    logic                   entry_vld;
    logic [DataWidth-1:0]   entry_data;
    logic                   deq_hsked;

    assign deq_hsked = deq_valid & deq_ready;

    // Enqueue wins over a dequeue in the same cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            entry_vld <= 1'b0;
        else if (enq_valid)
            entry_vld <= 1'b1;
        else if (deq_hsked)
            entry_vld <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (enq_valid)
            entry_data <= enq_data;
    end

    // Slot can take a completion only when empty
    assign enq_ready = !entry_vld;

    assign deq_valid = entry_vld;
    assign deq_data  = entry_data;

endmodule

/* source/rob_alloc.sv */
module rob_alloc #(
    parameter int RobSize = mpc_types::ROB_SIZE
)
(
    input  logic                            clk,
    input  logic                            rst_n,

    // Upstream request
    input  logic                            req_valid,
    output logic                            req_ready,
    input  logic [mpc_types::ADDR_W-1:0]    req_addr,

    // Downstream issue
    output logic                            d_rd_valid,
    output logic [mpc_types::ADDR_W-1:0]    d_rd_addr,
    output mpc_types::rob_id_t              d_rd_rob_id,

    // One credit back per upstream delivery
    input  logic                            credit_rtn
);

    // Counter must reach RobSize itself
    localparam int CntW = $clog2(RobSize + 1);

    logic [CntW-1:0]        credit_cnt;
    mpc_types::rob_id_t     wr_ptr;
    logic                   issue;

    // ------------------------------------------------------------
    // Acceptance and downstream issue
    // ------------------------------------------------------------

    assign req_ready = (credit_cnt != '0);
    assign issue     = req_valid & req_ready;

    // Same cycle as the accept, no downstream ready
    assign d_rd_valid  = issue;
    assign d_rd_addr   = req_addr;
    assign d_rd_rob_id = wr_ptr;

    // ------------------------------------------------------------
    // Credits
    // ------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            credit_cnt <= CntW'(RobSize);
        end
        else
        begin
            case ({issue, credit_rtn})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Write pointer, the next slot ID to hand out
    // ------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
        end
        else if (issue)
        begin
            if (wr_ptr == mpc_types::rob_id_t'(RobSize - 1))
                wr_ptr <= '0;
            else
                wr_ptr <= wr_ptr + 1'b1;
        end
    end

endmodule

/* source/rob.sv */
module rob #(
    parameter int RobSize   = mpc_types::ROB_SIZE,
    parameter int DataWidth = mpc_types::DATA_W
)
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Downstream completion, single-cycle strobe
    input  logic                    d_rc_valid,
    input  mpc_types::rob_id_t      d_rc_rob_id,
    input  logic [DataWidth-1:0]    d_rc_data,

    // Upstream channel
    input  logic                    u_kob_rob_req,
    input  logic                    u_ch_ready,
    output logic                    u_ch_valid,
    output logic [DataWidth-1:0]    u_ch_data,

    // To the allocator
    output logic                    credit_rtn
);

    logic [RobSize-1:0]     slot_free;
    logic [RobSize-1:0]     slot_valid;
    logic [RobSize-1:0]     slot_enq;
    logic [RobSize-1:0]     slot_deq;
    logic [DataWidth-1:0]   slot_data [RobSize];

    mpc_types::rob_id_t     rd_ptr;
    logic                   xfer;

    // ------------------------------------------------------------
    // Slot array
    // ------------------------------------------------------------

    generate
        for (genvar i = 0; i < RobSize; i++)
        begin : g_slot
            // Completion decode, only into an empty slot
            assign slot_enq[i] = d_rc_valid & slot_free[i]
                               & (d_rc_rob_id == mpc_types::rob_id_t'(i));

            // Only the head slot ever drains
            assign slot_deq[i] = u_kob_rob_req & u_ch_ready
                               & (rd_ptr == mpc_types::rob_id_t'(i));

            rob_entry #(
                .DataWidth  (DataWidth)
            ) u_rob_entry (
                .clk        (clk),
                .rst_n      (rst_n),
                .enq_valid  (slot_enq[i]),
                .enq_ready  (slot_free[i]),
                .enq_data   (d_rc_data),
                .deq_valid  (slot_valid[i]),
                .deq_ready  (slot_deq[i]),
                .deq_data   (slot_data[i])
            );
        end
    endgenerate

    // ------------------------------------------------------------
    // In-order drain
    // ------------------------------------------------------------

    assign u_ch_valid = u_kob_rob_req & slot_valid[rd_ptr];
    assign u_ch_data  = slot_data[rd_ptr];
    assign xfer       = u_ch_valid & u_ch_ready;

    // Freed slot goes back as a credit
    assign credit_rtn = xfer;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_ptr <= '0;
        end
        else if (xfer)
        begin
            if (rd_ptr == mpc_types::rob_id_t'(RobSize - 1))
                rd_ptr <= '0;
            else
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

/* source/mpc_read_path.sv */
module mpc_read_path #(
    parameter int RobSize   = mpc_types::ROB_SIZE,
    parameter int DataWidth = mpc_types::DATA_W
)
(
    input  logic                            clk,
    input  logic                            rst_n,

    // Upstream request
    input  logic                            req_valid,
    output logic                            req_ready,
    input  logic [mpc_types::ADDR_W-1:0]    req_addr,

    // Downstream issue
    output logic                            d_rd_valid,
    output logic [mpc_types::ADDR_W-1:0]    d_rd_addr,
    output mpc_types::rob_id_t              d_rd_rob_id,

    // Downstream completion
    input  logic                            d_rc_valid,
    input  mpc_types::rob_id_t              d_rc_rob_id,
    input  logic [DataWidth-1:0]            d_rc_data,

    // Upstream channel
    input  logic                            u_kob_rob_req,
    input  logic                            u_ch_ready,
    output logic                            u_ch_valid,
    output logic [DataWidth-1:0]            u_ch_data
);

    logic credit_rtn;

    // ------------------------------------------------------------
    // Slot allocation against credits
    // ------------------------------------------------------------

    rob_alloc #(
        .RobSize        (RobSize)
    ) u_rob_alloc (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_addr       (req_addr),
        .d_rd_valid     (d_rd_valid),
        .d_rd_addr      (d_rd_addr),
        .d_rd_rob_id    (d_rd_rob_id),
        .credit_rtn     (credit_rtn)
    );

    // ------------------------------------------------------------
    // Reorder buffer
    // ------------------------------------------------------------

    rob #(
        .RobSize        (RobSize),
        .DataWidth      (DataWidth)
    ) u_rob (
        .clk            (clk),
        .rst_n          (rst_n),
        .d_rc_valid     (d_rc_valid),
        .d_rc_rob_id    (d_rc_rob_id),
        .d_rc_data      (d_rc_data),
        .u_kob_rob_req  (u_kob_rob_req),
        .u_ch_ready     (u_ch_ready),
        .u_ch_valid     (u_ch_valid),
        .u_ch_data      (u_ch_data),
        .credit_rtn     (credit_rtn)
    );

endmodule

/* bench/rob_properties.sv */
module rob_properties #(
    parameter int RobSize   = mpc_types::ROB_SIZE,
    parameter int DataWidth = mpc_types::DATA_W
)
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_ready,
    input  logic                    d_rd_valid,
    input  logic                    d_rc_valid,
    input  mpc_types::rob_id_t      d_rc_rob_id,
    input  logic                    u_ch_valid,
    input  logic                    u_ch_ready,
    input  logic [DataWidth-1:0]    u_ch_data
);

    timeunit 1ns;
    timeprecision 1ns;

    // Slots holding a completion not yet delivered
    logic [RobSize-1:0]     held;
    mpc_types::rob_id_t     head;
    int                     outstanding;
    logic                   xfer;

    // Failed property count
    int                     assert_fails = 0;

    assign xfer = u_ch_valid & u_ch_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            held        <= '0;
            head        <= '0;
            outstanding <= 0;
        end
        else
        begin
            if (d_rc_valid)
                held[d_rc_rob_id] <= 1'b1;
            if (xfer)
            begin
                held[head] <= 1'b0;
                if (head == mpc_types::rob_id_t'(RobSize - 1))
                    head <= '0;
                else
                    head <= head + 1'b1;
            end
            outstanding <= outstanding + int'(d_rd_valid) - int'(xfer);
        end
    end

    // ------------------------------------------------------------
    // Properties
    // ------------------------------------------------------------

    no_fill_of_held_slot: assert property (@(posedge clk) disable iff (!rst_n)
        d_rc_valid |-> !held[d_rc_rob_id])
        else
        begin
            $error("completion written into a slot that still holds data");
            assert_fails++;
        end

    stable_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (u_ch_valid && !u_ch_ready) |=> (u_ch_valid && $stable(u_ch_data)))
        else
        begin
            $error("upstream channel changed while stalled");
            assert_fails++;
        end

    no_accept_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (outstanding == RobSize) |-> !req_ready)
        else
        begin
            $error("req_ready high with every slot outstanding");
            assert_fails++;
        end

endmodule

bind mpc_read_path rob_properties #(
    .RobSize        (RobSize),
    .DataWidth      (DataWidth)
) u_rob_properties (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_ready      (req_ready),
    .d_rd_valid     (d_rd_valid),
    .d_rc_valid     (d_rc_valid),
    .d_rc_rob_id    (d_rc_rob_id),
    .u_ch_valid     (u_ch_valid),
    .u_ch_ready     (u_ch_ready),
    .u_ch_data      (u_ch_data)
);

/* bench/mpc_read_path_tb.sv */
module mpc_read_path_tb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int TotalReq  = 249;
    localparam int MaxCycles = 200 * TotalReq + 1000;

    logic                               clk;
    logic                               rst_n;
    logic                               req_valid;
    logic                               req_ready;
    logic [mpc_types::ADDR_W-1:0]       req_addr;
    logic                               d_rd_valid;
    logic [mpc_types::ADDR_W-1:0]       d_rd_addr;
    mpc_types::rob_id_t                 d_rd_rob_id;
    logic                               d_rc_valid;
    mpc_types::rob_id_t                 d_rc_rob_id;
    mpc_types::data_t                   d_rc_data;
    logic                               u_kob_rob_req;
    logic                               u_ch_ready;
    logic                               u_ch_valid;
    mpc_types::data_t                   u_ch_data;

    // Expected upstream data in request order
    mpc_types::data_t                   exp_q [$];

    // Issued requests the memory has not answered yet
    mpc_types::rob_id_t                 pend_id [$];
    logic [mpc_types::ADDR_W-1:0]       pend_addr [$];
    int                                 pend_delay [$];

    bit     mem_hold     = 1'b0;
    bit     newest_first = 1'b0;
    bit     stall_on     = 1'b0;
    int     max_delay    = 0;
    int     stall_left   = 0;
    int     xfer_count   = 0;
    int     next_id      = 0;
    int     checks       = 0;
    int     errors       = 0;
    int     cycles       = 0;
    string  test_name    = "reset";

    mpc_read_path #(
        .RobSize        (mpc_types::ROB_SIZE),
        .DataWidth      (mpc_types::DATA_W)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_addr       (req_addr),
        .d_rd_valid     (d_rd_valid),
        .d_rd_addr      (d_rd_addr),
        .d_rd_rob_id    (d_rd_rob_id),
        .d_rc_valid     (d_rc_valid),
        .d_rc_rob_id    (d_rc_rob_id),
        .d_rc_data      (d_rc_data),
        .u_kob_rob_req  (u_kob_rob_req),
        .u_ch_ready     (u_ch_ready),
        .u_ch_valid     (u_ch_valid),
        .u_ch_data      (u_ch_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Reference model and checking
    // ------------------------------------------------------------

    function automatic mpc_types::data_t expected_data(input logic [mpc_types::ADDR_W-1:0] addr);
        return {4{addr}} ^ 128'h5a5a5a5a_5a5a5a5a_5a5a5a5a_5a5a5a5a;
    endfunction

    task automatic check_value(input string what, input mpc_types::data_t expected,
                               input mpc_types::data_t actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("error: %s, %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    // Accepted requests set the expected order and the expected issue
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            check_value("downstream issue valid", mpc_types::data_t'(req_valid && req_ready),
                        mpc_types::data_t'(d_rd_valid));
            if (req_valid && req_ready)
            begin
                exp_q.push_back(expected_data(req_addr));
                check_value("downstream address", mpc_types::data_t'(req_addr),
                            mpc_types::data_t'(d_rd_addr));
                check_value("downstream slot id", mpc_types::data_t'(next_id),
                            mpc_types::data_t'(d_rd_rob_id));
                if (next_id == mpc_types::ROB_SIZE - 1)
                    next_id = 0;
                else
                    next_id = next_id + 1;
            end
        end
    end

    // Memory sees only the downstream issue
    always @(posedge clk)
    begin
        if (rst_n && d_rd_valid)
        begin
            pend_id.push_back(d_rd_rob_id);
            pend_addr.push_back(d_rd_addr);
            pend_delay.push_back(int'($urandom_range(max_delay, 0)));
        end
    end

    always @(posedge clk)
    begin
        if (rst_n && u_ch_valid && u_ch_ready)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("upstream delivered data with no request outstanding in %s", test_name);
            end
            else
                check_value("upstream data", exp_q.pop_front(), u_ch_data);
            xfer_count++;
        end
    end

    initial
    begin
        while (cycles < MaxCycles)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles while running %s", cycles, test_name);
        $display("Some tests failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Out-of-order memory and upstream ready
    // ------------------------------------------------------------

    initial
    begin
        int pick;
        d_rc_valid  = 1'b0;
        d_rc_rob_id = '0;
        d_rc_data   = '0;
        forever
        begin
            @(negedge clk);
            d_rc_valid = 1'b0;
            foreach (pend_delay[k])
                if (pend_delay[k] > 0)
                    pend_delay[k] = pend_delay[k] - 1;
            if (rst_n && !mem_hold && pend_id.size() > 0)
            begin
                if (newest_first)
                    pick = pend_id.size() - 1;
                else
                    pick = int'($urandom_range(pend_id.size() - 1, 0));
                if (pend_delay[pick] == 0)
                begin
                    d_rc_valid  = 1'b1;
                    d_rc_rob_id = pend_id[pick];
                    d_rc_data   = expected_data(pend_addr[pick]);
                    pend_id.delete(pick);
                    pend_addr.delete(pick);
                    pend_delay.delete(pick);
                end
            end
        end
    end

    initial
    begin
        u_ch_ready = 1'b1;
        forever
        begin
            @(negedge clk);
            if (stall_left > 0)
                stall_left--;
            else if (stall_on && $urandom_range(3, 0) == 0)
                stall_left = int'($urandom_range(6, 1));
            u_ch_ready = (stall_left == 0);
        end
    end

    // ------------------------------------------------------------
    // Stimulus, all called on a falling edge
    // ------------------------------------------------------------

    task automatic send_request(input logic [mpc_types::ADDR_W-1:0] addr);
        req_valid = 1'b1;
        req_addr  = addr;
        while (!req_ready)
            @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic send_burst(input int count, input int max_gap);
        for (int n = 0; n < count; n++)
        begin
            send_request($urandom());
            repeat ($urandom_range(max_gap, 0)) @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || pend_id.size() != 0)
            @(negedge clk);
    endtask

    initial
    begin
        int base;
        void'($urandom(32'hebea));
        rst_n         = 1'b0;
        req_valid     = 1'b0;
        req_addr      = '0;
        u_kob_rob_req = 1'b1;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_name = "single request";
        send_burst(1, 0);
        wait_drain();

        // Reverse order first, then random
        test_name = "reverse completions";
        max_delay = 0;
        mem_hold  = 1'b1;
        send_burst(8, 0);
        newest_first = 1'b1;
        mem_hold     = 1'b0;
        wait_drain();
        newest_first = 1'b0;
        test_name    = "random completions";
        max_delay    = 10;
        send_burst(8, 1);
        wait_drain();

        test_name = "upstream back-pressure";
        stall_on  = 1'b1;
        max_delay = 6;
        send_burst(16, 1);
        wait_drain();
        stall_on = 1'b0;
        while (stall_left != 0)
            @(negedge clk);

        test_name = "credits exhausted";
        mem_hold  = 1'b1;
        send_burst(8, 0);
        repeat (5) @(negedge clk);
        check_value("req_ready with all credits used", '0, mpc_types::data_t'(req_ready));
        base     = xfer_count;
        mem_hold = 1'b0;
        while (xfer_count == base)
            @(negedge clk);
        check_value("req_ready after one delivery", mpc_types::data_t'(1'b1),
                    mpc_types::data_t'(req_ready));
        wait_drain();

        test_name     = "upstream not requesting";
        u_kob_rob_req = 1'b0;
        base          = xfer_count;
        max_delay     = 4;
        send_burst(8, 0);
        while (pend_id.size() != 0)
            @(negedge clk);
        repeat (3) @(negedge clk);
        check_value("transfers while not requesting", mpc_types::data_t'(base),
                    mpc_types::data_t'(xfer_count));
        u_kob_rob_req = 1'b1;
        wait_drain();

        test_name = "random traffic";
        stall_on  = 1'b1;
        max_delay = 20;
        send_burst(200, 2);
        wait_drain();
        stall_on = 1'b0;

        repeat (4) @(negedge clk);
        errors += DUT.u_rob_properties.assert_fails;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* filelist.f */
source/mpc_types.sv
source/rob_entry.sv
source/rob_alloc.sv
source/rob.sv
source/mpc_read_path.sv
bench/rob_properties.sv
bench/mpc_read_path_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := mpc_read_path_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation status is ignored here, the log search decides
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
